//--- hw/vga_pkg.sv
package vga_pkg;

  // Raster timing, 800x600 visible inside a 1040x666 frame
  localparam int H_ACTIVE     = 800;
  localparam int H_TOTAL      = 1040;
  localparam int H_SYNC_START = 856;
  localparam int H_SYNC_END   = 975;
  localparam int V_ACTIVE     = 600;
  localparam int V_TOTAL      = 666;
  localparam int V_SYNC_START = 637;
  localparam int V_SYNC_END   = 643;
  // Counter value to port pixel
  localparam int PIPE_DEPTH   = 3;

  // Playfield and preview geometry
  localparam int CELL_SIZE = 16;
  localparam int PF_COLS   = 12;
  localparam int PF_ROWS   = 20;
  localparam int PF_X0     = 304;
  localparam int PF_Y0     = 140;
  localparam int PF_X1     = PF_X0 + PF_COLS * CELL_SIZE;
  localparam int PF_Y1     = PF_Y0 + PF_ROWS * CELL_SIZE;
  localparam int BORDER    = 4;
  localparam int PV_X0     = 560;
  localparam int PV_Y0     = 140;
  localparam int PV_COLS   = 4;
  localparam int PV_ROWS   = 2;

  // Read-outs
  localparam int NUM_X0       = 560;
  localparam int SCORE_Y0     = 220;
  localparam int LINES_Y0     = 240;
  localparam int LEVEL_Y0     = 260;
  localparam int SCORE_BITS   = 26;
  localparam int SCORE_DIGITS = 8;
  localparam int LEVEL_BITS   = 4;
  localparam int LEVEL_DIGITS = 1;
  localparam int GLYPH_SIZE   = 8;

  typedef struct packed {
    logic [1:0] r;
    logic [1:0] g;
    logic [1:0] b;
  } rgb_t;

  typedef struct packed {
    logic dav;
    rgb_t rgb;
  } layer_pix_t;

  typedef struct packed {
    logic [10:0] x;
    logic [9:0]  y;
  } screen_pos_t;

  typedef enum logic [3:0] {
    ST_IDLE  = 4'd0,
    ST_PLAY  = 4'd1,
    ST_PAUSE = 4'd2,
    ST_OVER  = 4'd3
  } game_state_t;

  // Border colour per game state
  localparam rgb_t COL_IDLE    = '{r: 2'd0, g: 2'd0, b: 2'd3};
  localparam rgb_t COL_PLAY    = '{r: 2'd0, g: 2'd3, b: 2'd0};
  localparam rgb_t COL_PAUSE   = '{r: 2'd3, g: 2'd3, b: 2'd0};
  localparam rgb_t COL_OVER    = '{r: 2'd3, g: 2'd0, b: 2'd0};
  localparam rgb_t COL_CELL    = '{r: 2'd0, g: 2'd3, b: 2'd3};
  localparam rgb_t COL_PREVIEW = '{r: 2'd3, g: 2'd0, b: 2'd3};
  localparam rgb_t COL_DIGIT   = '{r: 2'd3, g: 2'd3, b: 2'd3};

endpackage

//--- hw/raster_timing.sv
module raster_timing (
  input  logic                 clk,
  input  logic                 rst,
  output vga_pkg::screen_pos_t pos,
  output logic                 blank,
  output logic                 hs,
  output logic                 vs
);
  import vga_pkg::*;

  logic                  h_last;
  logic                  v_last;
  logic [PIPE_DEPTH-1:0] blank_d;
  logic [PIPE_DEPTH-1:0] hs_d;
  logic [PIPE_DEPTH-1:0] vs_d;

  assign h_last = (pos.x == 11'(H_TOTAL - 1));
  assign v_last = (pos.y == 10'(V_TOTAL - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      pos <= '0;
    end else if (h_last) begin
      pos.x <= '0;
      pos.y <= v_last ? 10'd0 : pos.y + 10'd1;
    end else begin
      pos.x <= pos.x + 11'd1;
    end
  end

  // Delay line so the syncs leave with the colour of their pixel
  always_ff @(posedge clk) begin
    if (rst) begin
      blank_d <= '0;
      hs_d    <= '0;
      vs_d    <= '0;
    end else begin
      blank_d <= {blank_d[PIPE_DEPTH-2:0], (pos.x >= H_ACTIVE) || (pos.y >= V_ACTIVE)};
      hs_d    <= {hs_d[PIPE_DEPTH-2:0], (pos.x >= H_SYNC_START) && (pos.x <= H_SYNC_END)};
      vs_d    <= {vs_d[PIPE_DEPTH-2:0], (pos.y >= V_SYNC_START) && (pos.y <= V_SYNC_END)};
    end
  end

  assign blank = blank_d[PIPE_DEPTH-1];
  assign hs    = hs_d[PIPE_DEPTH-1];
  assign vs    = vs_d[PIPE_DEPTH-1];

endmodule

//--- hw/frame_layer.sv
module frame_layer (
  input  logic                 clk,
  input  logic                 rst,
  input  vga_pkg::screen_pos_t pos,
  input  vga_pkg::game_state_t game_state,
  output vga_pkg::layer_pix_t  pix
);
  import vga_pkg::*;

  logic       in_outer;
  logic       in_inner;
  rgb_t       state_col;
  layer_pix_t stage1;

  // Ring is the outer rectangle minus the playfield itself
  assign in_outer = (pos.x >= PF_X0 - BORDER) && (pos.x < PF_X1 + BORDER) &&
                    (pos.y >= PF_Y0 - BORDER) && (pos.y < PF_Y1 + BORDER);
  assign in_inner = (pos.x >= PF_X0) && (pos.x < PF_X1) &&
                    (pos.y >= PF_Y0) && (pos.y < PF_Y1);

  always_comb begin
    case (game_state)
      ST_PLAY:  state_col = COL_PLAY;
      ST_PAUSE: state_col = COL_PAUSE;
      ST_OVER:  state_col = COL_OVER;
      default:  state_col = COL_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stage1 <= '0;
      pix    <= '0;
    end else begin
      stage1 <= '{dav: in_outer && !in_inner, rgb: state_col};
      pix    <= stage1;
    end
  end

endmodule

//--- hw/block_layer.sv
module block_layer (
  input  logic                 clk,
  input  logic                 rst,
  input  vga_pkg::screen_pos_t pos,
  output logic [4:0]           game_area_addr,
  input  logic [11:0]          game_area_data,
  input  logic [7:0]           game_block_next,
  output vga_pkg::layer_pix_t  pix
);
  import vga_pkg::*;

  logic [10:0] dx;
  logic [9:0]  dy;
  logic [10:0] px;
  logic [9:0]  py;
  logic        in_rows;
  logic        in_field;
  logic        in_pv;
  // Stage 1 state
  logic [3:0]  col_q;
  logic [2:0]  pv_idx_q;
  logic        field_q;
  logic        pv_q;
  logic        cell_bit;
  logic        pv_bit;

  assign dx = pos.x - 11'(PF_X0);
  assign dy = pos.y - 10'(PF_Y0);
  assign px = pos.x - 11'(PV_X0);
  assign py = pos.y - 10'(PV_Y0);

  assign in_rows  = (pos.y >= PF_Y0) && (pos.y < PF_Y1);
  assign in_field = in_rows && (pos.x >= PF_X0) && (pos.x < PF_X1);
  assign in_pv    = (pos.x >= PV_X0) && (pos.x < PV_X0 + PV_COLS * CELL_SIZE) &&
                    (pos.y >= PV_Y0) && (pos.y < PV_Y0 + PV_ROWS * CELL_SIZE);

  // Row memory answers one cycle later, in step with stage 1
  assign game_area_addr = in_rows ? dy[8:4] : 5'd0;

  always_ff @(posedge clk) begin
    if (rst) begin
      field_q <= 1'b0;
      pv_q    <= 1'b0;
    end else begin
      field_q <= in_field;
      pv_q    <= in_pv;
    end
  end

  always_ff @(posedge clk) begin
    col_q    <= dx[7:4];
    pv_idx_q <= {py[4], px[5:4]};
  end

  // Bit 11 of a row and bit 7 of the preview are the leftmost cells
  assign cell_bit = game_area_data[4'd11 - col_q];
  assign pv_bit   = game_block_next[3'd7 - pv_idx_q];

  always_ff @(posedge clk) begin
    if (rst) begin
      pix <= '0;
    end else begin
      pix.dav <= (field_q && cell_bit) || (pv_q && pv_bit);
      pix.rgb <= field_q ? COL_CELL : COL_PREVIEW;
    end
  end

endmodule

//--- hw/bin_to_bcd.sv
module bin_to_bcd #(
  parameter int BITS   = 26,
  parameter int DIGITS = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  logic [BITS-1:0]       bin,
  output logic [4*DIGITS-1:0]   bcd,
  output logic                  done
);

  localparam int CNT_W = $clog2(BITS + 1);

  logic [BITS-1:0]     sh;
  logic [4*DIGITS-1:0] acc;
  logic [4*DIGITS-1:0] adj;
  logic [CNT_W-1:0]    cnt;
  logic                busy;

  // Add 3 to every digit of 5 or more before the shift
  always_comb begin
    adj = acc;
    for (int i = 0; i < DIGITS; i++) begin
      if (acc[4*i +: 4] >= 4'd5) begin
        adj[4*i +: 4] = acc[4*i +: 4] + 4'd3;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      done <= 1'b0;
      cnt  <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        cnt  <= CNT_W'(BITS);
      end else if (busy) begin
        cnt <= cnt - 1'b1;
        if (cnt == CNT_W'(1)) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // One input bit per cycle, MSB first
  always_ff @(posedge clk) begin
    if (start) begin
      sh  <= bin;
      acc <= '0;
    end else if (busy) begin
      sh  <= sh << 1;
      acc <= {adj[4*DIGITS-2:0], sh[BITS-1]};
    end
  end

  assign bcd = acc;

endmodule

//--- hw/number_layer.sv
module number_layer #(
  parameter int BITS   = 26,
  parameter int DIGITS = 8,
  parameter int Y0     = 220
) (
  input  logic                 clk,
  input  logic                 rst,
  input  vga_pkg::screen_pos_t pos,
  input  logic [BITS-1:0]      bin,
  output logic                 hit,
  output logic [6:0]           glyph_addr,
  output logic [2:0]           glyph_col
);
  import vga_pkg::*;

  logic                start;
  logic                done;
  logic [4*DIGITS-1:0] bcd;
  logic [4*DIGITS-1:0] bcd_q;
  logic [10:0]         dx;
  logic [9:0]          dy;
  logic                in_box;
  int                  idx;
  logic [3:0]          digit;

  // Sample once per frame at the start of vertical blanking
  assign start = (pos.x == 11'd0) && (pos.y == 10'(V_ACTIVE));

  bin_to_bcd #(
    .BITS   (BITS),
    .DIGITS (DIGITS)
  ) i_bin_to_bcd (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .bin   (bin),
    .bcd   (bcd),
    .done  (done)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      bcd_q <= '0;
    end else if (done) begin
      bcd_q <= bcd;
    end
  end

  assign dx = pos.x - 11'(NUM_X0);
  assign dy = pos.y - 10'(Y0);
  assign in_box = (pos.x >= NUM_X0) && (pos.x < NUM_X0 + DIGITS * GLYPH_SIZE) &&
                  (pos.y >= Y0) && (pos.y < Y0 + GLYPH_SIZE);

  // Most significant digit sits leftmost
  always_comb begin
    idx = 0;
    if (in_box) begin
      idx = DIGITS - 1 - int'(dx[10:3]);
    end
    digit = bcd_q[4*idx +: 4];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hit <= 1'b0;
    end else begin
      hit <= in_box;
    end
  end

  always_ff @(posedge clk) begin
    glyph_addr <= {digit, dy[2:0]};
    glyph_col  <= dx[2:0];
  end

endmodule

//--- hw/digit_rom.sv
module digit_rom (
  input  logic       clk,
  input  logic [6:0] addr,
  output logic [7:0] data
);

  // Ten glyphs of eight rows each
  logic [7:0] mem [0:79];

  initial begin
    $readmemh("digits.hex", mem);
  end

  always_ff @(posedge clk) begin
    data <= mem[addr];
  end

endmodule

//--- hw/vga_display.sv
module vga_display (
  input  logic                 clk,
  input  logic                 rst,
  input  vga_pkg::game_state_t game_state,
  input  logic [25:0]          game_points,
  input  logic [25:0]          game_lines,
  input  logic [3:0]           game_level,
  input  logic [7:0]           game_block_next,
  output logic [4:0]           game_area_addr,
  input  logic [11:0]          game_area_data,
  output logic                 vga_hs,
  output logic                 vga_vs,
  output vga_pkg::rgb_t        vga_rgb
);
  import vga_pkg::*;

  screen_pos_t pos;
  logic        blank;
  layer_pix_t  frame_pix;
  layer_pix_t  block_pix;
  layer_pix_t  digit_pix;
  logic        score_hit, lines_hit, level_hit;
  logic [6:0]  score_addr, lines_addr, level_addr;
  logic [2:0]  score_col, lines_col, level_col;
  logic [6:0]  rom_addr;
  logic [2:0]  col_sel;
  logic [7:0]  glyph_row;
  logic        num_hit_q;
  logic [2:0]  glyph_col_q;
  rgb_t        rgb_q;

  raster_timing i_raster_timing (
    .clk (clk), .rst (rst), .pos (pos), .blank (blank), .hs (vga_hs), .vs (vga_vs)
  );

  frame_layer i_frame_layer (
    .clk (clk), .rst (rst), .pos (pos), .game_state (game_state), .pix (frame_pix)
  );

  block_layer i_block_layer (
    .clk             (clk),
    .rst             (rst),
    .pos             (pos),
    .game_area_addr  (game_area_addr),
    .game_area_data  (game_area_data),
    .game_block_next (game_block_next),
    .pix             (block_pix)
  );

  number_layer #(.BITS(SCORE_BITS), .DIGITS(SCORE_DIGITS), .Y0(SCORE_Y0)) i_score (
    .clk (clk), .rst (rst), .pos (pos), .bin (game_points),
    .hit (score_hit), .glyph_addr (score_addr), .glyph_col (score_col)
  );

  number_layer #(.BITS(SCORE_BITS), .DIGITS(SCORE_DIGITS), .Y0(LINES_Y0)) i_lines (
    .clk (clk), .rst (rst), .pos (pos), .bin (game_lines),
    .hit (lines_hit), .glyph_addr (lines_addr), .glyph_col (lines_col)
  );

  number_layer #(.BITS(LEVEL_BITS), .DIGITS(LEVEL_DIGITS), .Y0(LEVEL_Y0)) i_level (
    .clk (clk), .rst (rst), .pos (pos), .bin (game_level),
    .hit (level_hit), .glyph_addr (level_addr), .glyph_col (level_col)
  );

  // Read-outs never overlap, so one ROM port serves all three
  always_comb begin
    if (lines_hit) begin
      rom_addr = lines_addr;
      col_sel  = lines_col;
    end else if (level_hit) begin
      rom_addr = level_addr;
      col_sel  = level_col;
    end else begin
      rom_addr = score_addr;
      col_sel  = score_col;
    end
  end

  digit_rom i_digit_rom (.clk (clk), .addr (rom_addr), .data (glyph_row));

  // Match the ROM read latency
  always_ff @(posedge clk) begin
    if (rst) begin
      num_hit_q <= 1'b0;
    end else begin
      num_hit_q <= score_hit || lines_hit || level_hit;
    end
  end

  always_ff @(posedge clk) begin
    glyph_col_q <= col_sel;
  end

  assign digit_pix.dav = num_hit_q && glyph_row[3'd7 - glyph_col_q];
  assign digit_pix.rgb = COL_DIGIT;

  // Border over cells over digits over background
  always_ff @(posedge clk) begin
    if (rst) begin
      rgb_q <= '0;
    end else if (frame_pix.dav) begin
      rgb_q <= frame_pix.rgb;
    end else if (block_pix.dav) begin
      rgb_q <= block_pix.rgb;
    end else if (digit_pix.dav) begin
      rgb_q <= digit_pix.rgb;
    end else begin
      rgb_q <= '0;
    end
  end

  assign vga_rgb = blank ? rgb_t'('0) : rgb_q;

endmodule

//--- tb/vga_display_assertions.sv
module vga_display_assertions (
  input logic                 clk,
  input logic                 rst,
  input logic                 hs,
  input vga_pkg::screen_pos_t pos,
  input vga_pkg::rgb_t        rgb
);
  timeunit 1ns;
  timeprecision 100ps;
  import vga_pkg::*;

  // Length of the current hsync pulse
  int unsigned hs_len;
  // Failed assertion count
  int unsigned failures = 0;
  logic        pos_blank;

  // Blanking of the counter position, three cycles ahead of the port
  assign pos_blank = (pos.x >= H_ACTIVE) || (pos.y >= V_ACTIVE);

  always @(posedge clk) begin
    if (rst || !hs) begin
      hs_len <= 0;
    end else begin
      hs_len <= hs_len + 1;
    end
  end

  hs_width_end: assert property (@(posedge clk) disable iff (rst) $fell(hs) |-> hs_len == 120)
    else begin
      failures++;
      $error("hsync pulse ended after %0d cycles", hs_len);
    end

  hs_width_max: assert property (@(posedge clk) disable iff (rst) hs |-> hs_len < 120)
    else begin
      failures++;
      $error("hsync pulse longer than 120 cycles");
    end

  blank_black: assert property (@(posedge clk) disable iff (rst)
                                $past(pos_blank, PIPE_DEPTH) |-> rgb == '0)
    else begin
      failures++;
      $error("colour not black during blanking");
    end

endmodule

bind vga_display vga_display_assertions i_vga_display_assertions (
  .clk (clk),
  .rst (rst),
  .hs  (vga_hs),
  .pos (pos),
  .rgb (vga_rgb)
);

//--- tb/vga_display_tb.sv
module vga_display_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import vga_pkg::*;

  localparam int     CLK_PERIOD = 100;
  localparam longint FRAME_NS   = longint'(H_TOTAL) * V_TOTAL * CLK_PERIOD;

  typedef struct packed {
    logic        live;
    screen_pos_t pos;
    logic        hs;
    logic        vs;
    rgb_t        rgb;
  } pixel_exp_t;

  logic        clk = 1'b0;
  logic        rst;
  game_state_t game_state;
  logic [25:0] game_points;
  logic [25:0] game_lines;
  logic [3:0]  game_level;
  logic [7:0]  game_block_next;
  logic [4:0]  game_area_addr;
  logic [11:0] game_area_data;
  logic        vga_hs;
  logic        vga_vs;
  rgb_t        vga_rgb;

  logic [11:0] area_rows [0:31];
  logic [4:0]  addr_q;
  logic [31:0] rng = 32'd38;
  int          cx;
  int          cy;
  int          shown_points;
  int          shown_lines;
  int          shown_level;
  pixel_exp_t  exp_pipe [0:2];
  int          checks;
  int          sync_errors;
  int          colour_errors;
  int          addr_errors;
  int          assert_failures;

  vga_display i_vga_display (
    .clk             (clk),
    .rst             (rst),
    .game_state      (game_state),
    .game_points     (game_points),
    .game_lines      (game_lines),
    .game_level      (game_level),
    .game_block_next (game_block_next),
    .game_area_addr  (game_area_addr),
    .game_area_data  (game_area_data),
    .vga_hs          (vga_hs),
    .vga_vs          (vga_vs),
    .vga_rgb         (vga_rgb)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Row memory with one cycle of read latency
  always @(negedge clk) begin
    addr_q <= game_area_addr;
  end

  always @(posedge clk) begin
    #1;
    game_area_data <= area_rows[addr_q];
  end

  // Raster position as the DUT counter should hold it
  always @(posedge clk) begin
    if (rst) begin
      cx <= 0;
      cy <= 0;
    end else if (cx == H_TOTAL - 1) begin
      cx <= 0;
      cy <= (cy == V_TOTAL - 1) ? 0 : cy + 1;
    end else begin
      cx <= cx + 1;
    end
  end

  function automatic logic [63:0] glyph(input int d);
    case (d)
      0: return 64'h3C666E7666663C00;
      1: return 64'h183818181818_7E00;
      2: return 64'h3C66060C30607E00;
      3: return 64'h3C66061C06663C00;
      4: return 64'h0C1C3C6C7E0C0C00;
      5: return 64'h7E607C0606663C00;
      6: return 64'h3C66607C66663C00;
      7: return 64'h7E660C1818181800;
      8: return 64'h3C66663C66663C00;
      9: return 64'h3C66663E06663C00;
      default: return 64'h0;
    endcase
  endfunction

  function automatic logic in_field(input int x, input int y);
    return x >= PF_X0 && x < PF_X0 + PF_COLS * CELL_SIZE &&
           y >= PF_Y0 && y < PF_Y0 + PF_ROWS * CELL_SIZE;
  endfunction

  function automatic logic in_border(input int x, input int y);
    logic outer;
    outer = x >= PF_X0 - BORDER && x < PF_X0 + PF_COLS * CELL_SIZE + BORDER &&
            y >= PF_Y0 - BORDER && y < PF_Y0 + PF_ROWS * CELL_SIZE + BORDER;
    return outer && !in_field(x, y);
  endfunction

  function automatic logic in_preview(input int x, input int y);
    return x >= PV_X0 && x < PV_X0 + 4 * CELL_SIZE && y >= PV_Y0 && y < PV_Y0 + 2 * CELL_SIZE;
  endfunction

  function automatic logic cell_on(input int x, input int y);
    if (!in_field(x, y)) begin
      return 1'b0;
    end
    return area_rows[(y - PF_Y0) / CELL_SIZE][11 - (x - PF_X0) / CELL_SIZE];
  endfunction

  function automatic logic preview_on(input int x, input int y, input logic [7:0] next);
    int idx;
    if (!in_preview(x, y)) begin
      return 1'b0;
    end
    idx = ((y - PV_Y0) / CELL_SIZE) * 4 + (x - PV_X0) / CELL_SIZE;
    return next[7 - idx];
  endfunction

  function automatic logic digit_on(input int x, input int y, input int val, input int y0,
                                    input int digits);
    int          i;
    int          p;
    logic [63:0] g;
    logic [7:0]  row_bits;
    if (x < NUM_X0 || x >= NUM_X0 + digits * GLYPH_SIZE || y < y0 || y >= y0 + GLYPH_SIZE) begin
      return 1'b0;
    end
    i = (x - NUM_X0) / GLYPH_SIZE;
    p = 1;
    // Leftmost box holds the most significant digit
    for (int k = 0; k < digits - 1 - i; k++) begin
      p = p * 10;
    end
    g = glyph((val / p) % 10);
    row_bits = g[63 - 8 * (y - y0) -: 8];
    return row_bits[7 - (x - NUM_X0) % GLYPH_SIZE];
  endfunction

  function automatic pixel_exp_t expected_pixel(input int x, input int y, input game_state_t st,
                                                input logic [7:0] next, input int points,
                                                input int lines, input int level);
    pixel_exp_t e;
    rgb_t       border_col;
    case (st)
      ST_PLAY:  border_col = COL_PLAY;
      ST_PAUSE: border_col = COL_PAUSE;
      ST_OVER:  border_col = COL_OVER;
      default:  border_col = COL_IDLE;
    endcase
    e.live = 1'b1;
    e.pos  = '{x: 11'(x), y: 10'(y)};
    e.hs   = x >= H_SYNC_START && x <= H_SYNC_END;
    e.vs   = y >= V_SYNC_START && y <= V_SYNC_END;
    if (x >= H_ACTIVE || y >= V_ACTIVE) begin
      e.rgb = '0;
    end else if (in_border(x, y)) begin
      e.rgb = border_col;
    end else if (cell_on(x, y)) begin
      e.rgb = COL_CELL;
    end else if (preview_on(x, y, next)) begin
      e.rgb = COL_PREVIEW;
    end else if (digit_on(x, y, points, SCORE_Y0, SCORE_DIGITS) ||
                 digit_on(x, y, lines, LINES_Y0, SCORE_DIGITS) ||
                 digit_on(x, y, level, LEVEL_Y0, LEVEL_DIGITS)) begin
      e.rgb = COL_DIGIT;
    end else begin
      e.rgb = '0;
    end
    return e;
  endfunction

  function automatic string region_name(input pixel_exp_t e);
    int x;
    int y;
    x = int'(e.pos.x);
    y = int'(e.pos.y);
    if (!e.live) return "reset";
    if (x >= H_ACTIVE || y >= V_ACTIVE) return "blanking";
    if (in_border(x, y)) return "border";
    if (in_field(x, y)) return "cells";
    if (in_preview(x, y)) return "preview";
    if (x >= NUM_X0 && y >= SCORE_Y0 && y < LEVEL_Y0 + GLYPH_SIZE) return "readouts";
    return "background";
  endfunction

  // Outputs now belong to the position seen three cycles earlier
  always @(negedge clk) begin
    pixel_exp_t exp_now;
    pixel_exp_t exp_old;
    logic [4:0] exp_addr;
    if (rst) begin
      exp_now      = '0;
      shown_points = 0;
      shown_lines  = 0;
      shown_level  = 0;
    end else begin
      if (cx == 0 && cy == V_ACTIVE) begin
        shown_points = int'(game_points);
        shown_lines  = int'(game_lines);
        shown_level  = int'(game_level);
      end
      exp_now = expected_pixel(cx, cy, game_state, game_block_next,
                               shown_points, shown_lines, shown_level);
    end
    // Row address follows the current line without delay
    exp_addr = 5'd0;
    if (cy >= PF_Y0 && cy < PF_Y0 + PF_ROWS * CELL_SIZE) begin
      exp_addr = 5'((cy - PF_Y0) / CELL_SIZE);
    end
    if (game_area_addr !== exp_addr) begin
      addr_errors++;
      $display("CHECK FAILED row address at line %0d: expected %0d, actual %0d",
               cy, exp_addr, game_area_addr);
    end
    exp_old = exp_pipe[2];
    checks++;
    if (vga_hs !== exp_old.hs) begin
      sync_errors++;
      $display("CHECK FAILED hsync %s at (%0d,%0d): expected %b, actual %b",
               region_name(exp_old), exp_old.pos.x, exp_old.pos.y, exp_old.hs, vga_hs);
    end
    if (vga_vs !== exp_old.vs) begin
      sync_errors++;
      $display("CHECK FAILED vsync %s at (%0d,%0d): expected %b, actual %b",
               region_name(exp_old), exp_old.pos.x, exp_old.pos.y, exp_old.vs, vga_vs);
    end
    if (vga_rgb !== exp_old.rgb) begin
      colour_errors++;
      $display("CHECK FAILED colour %s at (%0d,%0d): expected %h, actual %h",
               region_name(exp_old), exp_old.pos.x, exp_old.pos.y, exp_old.rgb, vga_rgb);
    end
    exp_pipe[2] = exp_pipe[1];
    exp_pipe[1] = exp_pipe[0];
    exp_pipe[0] = exp_now;
  end

  task automatic advance_to(input int x, input int y);
    @(posedge clk);
    #1;
    while (cx != x || cy != y) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    #(5 * FRAME_NS);
    $display("Watchdog expired after five frame times, run did not finish");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    rst             = 1'b1;
    game_state      = ST_IDLE;
    game_points     = 26'(next_rand());
    game_lines      = 26'(next_rand());
    game_level      = 4'(next_rand() % 10);
    game_block_next = 8'(next_rand());
    game_area_data  = '0;
    exp_pipe[0]     = '0;
    exp_pipe[1]     = '0;
    exp_pipe[2]     = '0;
    for (int i = 0; i < 32; i++) begin
      area_rows[i] = 12'(next_rand());
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    // One frame per game state
    for (int f = 0; f < 4; f++) begin
      // Mid-frame change, visible only from the next frame
      advance_to(0, SCORE_Y0 + 4);
      game_points = 26'(next_rand());
      game_lines  = 26'(next_rand());
      game_level  = 4'(next_rand() % 10);
      advance_to(0, 610);
      if (f < 3) begin
        game_state      = game_state_t'(f + 1);
        game_block_next = 8'(next_rand());
      end
    end
    advance_to(16, 0);

    assert_failures = int'(i_vga_display.i_vga_display_assertions.failures);
    $display("Checked %0d pixels: %0d sync, %0d colour, %0d address, %0d assertion errors",
             checks, sync_errors, colour_errors, addr_errors, assert_failures);
    if (sync_errors == 0 && colour_errors == 0 && addr_errors == 0 &&
        assert_failures == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- digits.hex
// One glyph row per line, bit 7 is the leftmost pixel; digits 0 to 9, eight rows each
3C
66
6E
76
66
66
3C
00
18
38
18
18
18
18
7E
00
3C
66
06
0C
30
60
7E
00
3C
66
06
1C
06
66
3C
00
0C
1C
3C
6C
7E
0C
0C
00
7E
60
7C
06
06
66
3C
00
3C
66
60
7C
66
66
3C
00
7E
66
0C
18
18
18
18
00
3C
66
66
3C
66
66
3C
00
3C
66
66
3E
06
66
3C
00

//--- vlog.f
hw/vga_pkg.sv
hw/raster_timing.sv
hw/frame_layer.sv
hw/block_layer.sv
hw/bin_to_bcd.sv
hw/number_layer.sv
hw/digit_rom.sv
hw/vga_display.sv
tb/vga_display_assertions.sv
tb/vga_display_tb.sv

//--- run.sh
#!/bin/sh
# Build and run with Verilator from the project root, pass only if the pass message shows up
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module vga_display_tb -f vlog.f \
  && ./obj_dir/Vvga_display_tb | tee /dev/stderr | grep -q "TEST PASSED" \
  || { echo "run.sh: simulation did not pass"; exit 1; }
